/* common/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // ----------------------------------------
  // Bus types
  // ----------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  gpio_t;

  // Byte offset of a register inside a 256-byte peripheral window
  typedef logic [7:0]  reg_off_t;

  typedef enum logic [7:0] {
    DBG_NOP        = 8'd0,
    DBG_READ       = 8'd1,
    DBG_WRITE      = 8'd2,
    DBG_PERIPH_RST = 8'd3
  } dbg_cmd_t;

  // ----------------------------------------
  // Memory map, end addresses exclusive
  // ----------------------------------------
  localparam addr_t RAM_START   = 32'h0000_0000;
  localparam addr_t RAM_END     = 32'h0000_0400;
  localparam addr_t TIMER_START = 32'h0000_8000;
  localparam addr_t TIMER_END   = 32'h0000_8100;
  localparam addr_t GPIO_START  = 32'h0000_8100;
  localparam addr_t GPIO_END    = 32'h0000_8200;

  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // Timer registers
  localparam reg_off_t TMR_CTRL  = 8'h00;
  localparam reg_off_t TMR_COUNT = 8'h04;
  localparam reg_off_t TMR_CMP   = 8'h08;

  // GPIO registers
  localparam reg_off_t GPIO_DIR = 8'h00;
  localparam reg_off_t GPIO_OUT = 8'h04;
  localparam reg_off_t GPIO_IN  = 8'h08;
  localparam reg_off_t GPIO_IRQ = 8'h0C;

endpackage

`default_nettype wire

/* debug/dbg_module.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_module import soc_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_i,
  // Debug port
  input  wire dbg_cmd_t cmd_i,
  input  wire addr_t    addr_i,
  input  wire data_t    data_i,
  output data_t         data_o,
  output logic          ready_o,
  output logic          periph_rst_o,
  // Wishbone master
  output logic          wb_cyc_o,
  output logic          wb_stb_o,
  output logic          wb_we_o,
  output addr_t         wb_adr_o,
  output data_t         wb_dat_o,
  input  wire data_t    wb_dat_i,
  input  wire logic     wb_ack_i
);

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    DONE,
    RESET
  } state_t;

  state_t state;

  logic  we_q;
  addr_t addr_q;
  data_t data_q;

  // ----------------------------------------
  // Command FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state  <= IDLE;
      data_o <= '0;
    end else begin
      case (state)
        IDLE: begin
          case (cmd_i)
            DBG_READ, DBG_WRITE: state <= BUS;
            DBG_PERIPH_RST:      state <= RESET;
            default:             state <= IDLE;
          endcase
        end
        BUS: begin
          // Single bus cycle, finished on the slave acknowledge
          if (wb_ack_i) begin
            state <= DONE;
            if (!we_q) begin
              data_o <= wb_dat_i;
            end
          end
        end
        RESET:   state <= DONE;
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Request fields, frozen outside IDLE
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      we_q   <= (cmd_i == DBG_WRITE);
      addr_q <= addr_i;
      data_q <= data_i;
    end
  end

  // ----------------------------------------
  // Outputs decoded from the state register
  // ----------------------------------------
  assign ready_o      = (state == IDLE);
  assign periph_rst_o = (state == RESET);

  assign wb_cyc_o = (state == BUS);
  assign wb_stb_o = (state == BUS);
  assign wb_we_o  = we_q;
  assign wb_adr_o = addr_q;
  assign wb_dat_o = data_q;

endmodule

`default_nettype wire

/* source/wb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_decoder import soc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_i,
  // Master side
  input  wire logic  m_cyc_i,
  input  wire logic  m_stb_i,
  input  wire logic  m_we_i,
  input  wire addr_t m_adr_i,
  input  wire data_t m_dat_i,
  output data_t      m_dat_o,
  output logic       m_ack_o,
  // Shared slave request
  output logic       s_cyc_o,
  output logic       s_we_o,
  output addr_t      s_adr_o,
  output data_t      s_dat_o,
  // Per-slave strobe and response
  output logic       ram_stb_o,
  output logic       tmr_stb_o,
  output logic       gpio_stb_o,
  input  wire data_t ram_dat_i,
  input  wire data_t tmr_dat_i,
  input  wire data_t gpio_dat_i,
  input  wire logic  ram_ack_i,
  input  wire logic  tmr_ack_i,
  input  wire logic  gpio_ack_i
);

  logic ram_sel;
  logic tmr_sel;
  logic gpio_sel;
  logic none_sel;
  logic none_ack;

  // Offset compare also rejects addresses below the start (wraps high)
  assign ram_sel  = (m_adr_i - RAM_START) < (RAM_END - RAM_START);
  assign tmr_sel  = (m_adr_i - TIMER_START) < (TIMER_END - TIMER_START);
  assign gpio_sel = (m_adr_i - GPIO_START) < (GPIO_END - GPIO_START);
  assign none_sel = ~(ram_sel | tmr_sel | gpio_sel);

  assign s_cyc_o = m_cyc_i;
  assign s_we_o  = m_we_i;
  assign s_adr_o = m_adr_i;
  assign s_dat_o = m_dat_i;

  assign ram_stb_o  = m_cyc_i & m_stb_i & ram_sel;
  assign tmr_stb_o  = m_cyc_i & m_stb_i & tmr_sel;
  assign gpio_stb_o = m_cyc_i & m_stb_i & gpio_sel;

  // Unmapped accesses get acknowledged here
  always_ff @(posedge clk) begin
    if (rst_i) begin
      none_ack <= 1'b0;
    end else begin
      none_ack <= m_cyc_i & m_stb_i & none_sel & ~none_ack;
    end
  end

  // Response mux, zero data for unmapped reads
  always_comb begin
    m_dat_o = '0;
    m_ack_o = none_ack;
    if (ram_sel) begin
      m_dat_o = ram_dat_i;
      m_ack_o = ram_ack_i;
    end else if (tmr_sel) begin
      m_dat_o = tmr_dat_i;
      m_ack_o = tmr_ack_i;
    end else if (gpio_sel) begin
      m_dat_o = gpio_dat_i;
      m_ack_o = gpio_ack_i;
    end
  end

endmodule

`default_nettype wire

/* source/wb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_ram import soc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_i,
  input  wire logic  cyc_i,
  input  wire logic  stb_i,
  input  wire logic  we_i,
  input  wire addr_t adr_i,
  input  wire data_t dat_i,
  output data_t      dat_o,
  output logic       ack_o
);

  data_t mem [RAM_WORDS];

  addr_t             off;
  logic [RAM_AW-1:0] idx;
  logic              access;

  // Word index within the RAM window
  assign off    = adr_i - RAM_START;
  assign idx    = off[RAM_AW+1:2];
  assign access = cyc_i & stb_i & ~ack_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // Write and registered read share the acknowledge edge
  always_ff @(posedge clk) begin
    if (access) begin
      if (we_i) begin
        mem[idx] <= dat_i;
      end
      dat_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

/* source/timer.sv */
`timescale 1ns/1ps
`default_nettype none

module timer import soc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_i,
  input  wire logic  cyc_i,
  input  wire logic  stb_i,
  input  wire logic  we_i,
  input  wire addr_t adr_i,
  input  wire data_t dat_i,
  output data_t      dat_o,
  output logic       ack_o,
  output logic       irq_o
);

  logic     en;
  data_t    count;
  data_t    cmp;
  reg_off_t off;
  logic     access;

  assign off    = adr_i[7:0];
  assign access = cyc_i & stb_i & ~ack_o;

  // ----------------------------------------
  // Counter and register writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      en    <= 1'b0;
      count <= '0;
      cmp   <= '0;
      irq_o <= 1'b0;
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
      irq_o <= 1'b0;
      if (en) begin
        // Restart also when compare was moved below the count
        if (count >= cmp) begin
          count <= '0;
          irq_o <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
      if (access && we_i) begin
        case (off)
          TMR_CTRL: en  <= dat_i[0];
          TMR_CMP:  cmp <= dat_i;
          default:  ;
        endcase
      end
    end
  end

  // Readback
  always_ff @(posedge clk) begin
    if (access) begin
      case (off)
        TMR_CTRL:  dat_o <= {31'b0, en};
        TMR_COUNT: dat_o <= count;
        TMR_CMP:   dat_o <= cmp;
        default:   dat_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/gpio_module.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_module import soc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_i,
  input  wire logic  cyc_i,
  input  wire logic  stb_i,
  input  wire logic  we_i,
  input  wire addr_t adr_i,
  input  wire data_t dat_i,
  input  wire gpio_t val_i,
  output data_t      dat_o,
  output logic       ack_o,
  output gpio_t      dir_o,
  output gpio_t      val_o,
  output logic       irq_o
);

  gpio_t    out_q;
  gpio_t    sync1;
  gpio_t    sync2;
  gpio_t    prev;
  gpio_t    status;
  gpio_t    clr;
  reg_off_t off;
  logic     access;

  assign off    = adr_i[7:0];
  assign access = cyc_i & stb_i & ~ack_o;
  assign clr    = (access && we_i && off == GPIO_IRQ) ? dat_i[7:0] : '0;

  // Input synchroniser, free running so a reset sees no false edge
  always_ff @(posedge clk) begin
    sync1 <= val_i;
    sync2 <= sync1;
    prev  <= sync2;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      dir_o  <= '0;
      out_q  <= '0;
      status <= '0;
      ack_o  <= 1'b0;
    end else begin
      ack_o <= access;
      // New edges win over a clear in the same cycle
      status <= (status & ~clr) | (sync2 & ~prev);
      if (access && we_i) begin
        case (off)
          GPIO_DIR: dir_o <= dat_i[7:0];
          GPIO_OUT: out_q <= dat_i[7:0];
          default:  ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (off)
        GPIO_DIR: dat_o <= {24'b0, dir_o};
        GPIO_OUT: dat_o <= {24'b0, val_o};
        GPIO_IN:  dat_o <= {24'b0, sync2};
        GPIO_IRQ: dat_o <= {24'b0, status};
        default:  dat_o <= '0;
      endcase
    end
  end

  assign val_o = out_q & dir_o;
  assign irq_o = |status;

endmodule

`default_nettype wire

/* source/core_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module core_wrapper import soc_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_i,
  // GPIO pins
  output gpio_t         gpio_dir_o,
  output gpio_t         gpio_val_o,
  input  wire gpio_t    gpio_val_i,
  // Debug port
  input  wire dbg_cmd_t dbg_cmd_i,
  input  wire addr_t    dbg_addr_i,
  input  wire data_t    dbg_data_i,
  output data_t         dbg_data_o,
  output logic          dbg_ready_o,
  // Interrupts
  output logic          timer_irq_o,
  output logic          gpio_irq_o
);

  logic  dbg_periph_rst;
  logic  periph_rst;

  // Master bus
  logic  m_cyc, m_stb, m_we, m_ack;
  addr_t m_adr;
  data_t m_dat_w, m_dat_r;

  // Slave bus
  logic  s_cyc, s_we;
  addr_t s_adr;
  data_t s_dat_w;
  logic  ram_stb, tmr_stb, gpio_stb;
  logic  ram_ack, tmr_ack, gpio_ack;
  data_t ram_dat, tmr_dat, gpio_dat;

  // Debug pulse resets peripherals only, RAM keeps its contents
  assign periph_rst = rst_i | dbg_periph_rst;

  dbg_module dbg_module_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .cmd_i        (dbg_cmd_i),
    .addr_i       (dbg_addr_i),
    .data_i       (dbg_data_i),
    .data_o       (dbg_data_o),
    .ready_o      (dbg_ready_o),
    .periph_rst_o (dbg_periph_rst),
    .wb_cyc_o     (m_cyc),
    .wb_stb_o     (m_stb),
    .wb_we_o      (m_we),
    .wb_adr_o     (m_adr),
    .wb_dat_o     (m_dat_w),
    .wb_dat_i     (m_dat_r),
    .wb_ack_i     (m_ack)
  );

  wb_decoder wb_decoder_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .m_cyc_i    (m_cyc),
    .m_stb_i    (m_stb),
    .m_we_i     (m_we),
    .m_adr_i    (m_adr),
    .m_dat_i    (m_dat_w),
    .m_dat_o    (m_dat_r),
    .m_ack_o    (m_ack),
    .s_cyc_o    (s_cyc),
    .s_we_o     (s_we),
    .s_adr_o    (s_adr),
    .s_dat_o    (s_dat_w),
    .ram_stb_o  (ram_stb),
    .tmr_stb_o  (tmr_stb),
    .gpio_stb_o (gpio_stb),
    .ram_dat_i  (ram_dat),
    .tmr_dat_i  (tmr_dat),
    .gpio_dat_i (gpio_dat),
    .ram_ack_i  (ram_ack),
    .tmr_ack_i  (tmr_ack),
    .gpio_ack_i (gpio_ack)
  );

  wb_ram ram_i (
    .clk   (clk),
    .rst_i (rst_i),
    .cyc_i (s_cyc),
    .stb_i (ram_stb),
    .we_i  (s_we),
    .adr_i (s_adr),
    .dat_i (s_dat_w),
    .dat_o (ram_dat),
    .ack_o (ram_ack)
  );

  timer timer_i (
    .clk   (clk),
    .rst_i (periph_rst),
    .cyc_i (s_cyc),
    .stb_i (tmr_stb),
    .we_i  (s_we),
    .adr_i (s_adr),
    .dat_i (s_dat_w),
    .dat_o (tmr_dat),
    .ack_o (tmr_ack),
    .irq_o (timer_irq_o)
  );

  gpio_module gpio_i (
    .clk   (clk),
    .rst_i (periph_rst),
    .cyc_i (s_cyc),
    .stb_i (gpio_stb),
    .we_i  (s_we),
    .adr_i (s_adr),
    .dat_i (s_dat_w),
    .val_i (gpio_val_i),
    .dat_o (gpio_dat),
    .ack_o (gpio_ack),
    .dir_o (gpio_dir_o),
    .val_o (gpio_val_o),
    .irq_o (gpio_irq_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_core_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_wrapper import soc_pkg::*; ();

  localparam int READY_TIMEOUT = 100;
  localparam int IRQ_TIMEOUT   = 200;

  logic     clk;
  logic     rst_i;
  gpio_t    gpio_val_i;
  dbg_cmd_t dbg_cmd_i;
  addr_t    dbg_addr_i;
  data_t    dbg_data_i;
  gpio_t    gpio_dir_o;
  gpio_t    gpio_val_o;
  data_t    dbg_data_o;
  logic     dbg_ready_o;
  logic     timer_irq_o;
  logic     gpio_irq_o;

  // Reference model of RAM and peripheral registers
  data_t ram_m [RAM_WORDS];
  gpio_t dir_m;
  gpio_t out_m;
  gpio_t in_m;
  gpio_t irq_m;
  data_t cmp_m;

  int errors;
  int timeouts;

  core_wrapper uut (
    .clk         (clk),
    .rst_i       (rst_i),
    .gpio_dir_o  (gpio_dir_o),
    .gpio_val_o  (gpio_val_o),
    .gpio_val_i  (gpio_val_i),
    .dbg_cmd_i   (dbg_cmd_i),
    .dbg_addr_i  (dbg_addr_i),
    .dbg_data_i  (dbg_data_i),
    .dbg_data_o  (dbg_data_o),
    .dbg_ready_o (dbg_ready_o),
    .timer_irq_o (timer_irq_o),
    .gpio_irq_o  (gpio_irq_o)
  );

  always #10 clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Counts the cycles spent with the port busy
  task automatic wait_ready(input string what, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!dbg_ready_o && cycles < READY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!dbg_ready_o) begin
      timeouts++;
      $display("Timeout: debug port never became ready %s", what);
    end
  endtask

  // Command held for one cycle, then back to NOP
  task automatic issue_cmd(input dbg_cmd_t cmd, input addr_t addr, input data_t data);
    int lat;
    int exp_lat;
    // Bus commands take three cycles, the reset pulse two
    exp_lat = (cmd == DBG_PERIPH_RST) ? 2 : 3;
    wait_ready("before a command", lat);
    @(posedge clk);
    dbg_cmd_i  <= cmd;
    dbg_addr_i <= addr;
    dbg_data_i <= data;
    @(posedge clk);
    dbg_cmd_i <= DBG_NOP;
    wait_ready("after a command", lat);
    check("dbg_ready_o latency", 32'(lat), 32'(exp_lat));
  endtask

  task automatic bus_write(input addr_t addr, input data_t data);
    issue_cmd(DBG_WRITE, addr, data);
  endtask

  task automatic bus_read(input addr_t addr, output data_t value);
    issue_cmd(DBG_READ, addr, '0);
    value = dbg_data_o;
  endtask

  task automatic read_expect(input string name, input addr_t addr, input data_t exp);
    data_t value;
    bus_read(addr, value);
    check(name, value, exp);
  endtask

  // Fill word built from every bit of the word index
  function automatic data_t fill_word(input int idx);
    return {8'(idx), ~8'(idx), 8'(idx) ^ 8'h5A, 8'(idx * 7 + 3)};
  endfunction

  task automatic wait_timer_irq();
    int cycles;
    cycles = 0;
    while (!timer_irq_o && cycles < IRQ_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!timer_irq_o) begin
      timeouts++;
      $display("Timeout: timer interrupt never pulsed");
    end
  endtask

  task automatic settle_inputs(input gpio_t pat);
    @(posedge clk);
    gpio_val_i <= pat;
    // Two-flop synchroniser plus edge register
    repeat (4) @(posedge clk);
    irq_m = irq_m | (pat & ~in_m);
    in_m  = pat;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int    idx;
    addr_t addr;
    data_t value;
    gpio_t pat;
    logic  saw_irq;

    void'($urandom(25));
    clk        = 1'b0;
    rst_i      = 1'b1;
    gpio_val_i = '0;
    dbg_cmd_i  = DBG_NOP;
    dbg_addr_i = '0;
    dbg_data_i = '0;
    errors     = 0;
    timeouts   = 0;
    dir_m      = '0;
    out_m      = '0;
    in_m       = '0;
    irq_m      = '0;
    cmp_m      = '0;
    saw_irq    = 1'b0;

    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check("dbg_ready_o", 32'(dbg_ready_o), 32'd1);
    check("timer_irq_o", 32'(timer_irq_o), 32'd0);
    check("gpio_irq_o", 32'(gpio_irq_o), 32'd0);
    check("gpio_dir_o", 32'(gpio_dir_o), 32'd0);
    check("gpio_val_o", 32'(gpio_val_o), 32'd0);

    // RAM preload and random traffic
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram_m[i] = fill_word(i);
      bus_write(RAM_START + 32'(i * 4), ram_m[i]);
    end
    for (int i = 0; i < 40; i++) begin
      idx        = $urandom % RAM_WORDS;
      ram_m[idx] = data_t'($urandom);
      bus_write(RAM_START + 32'(idx * 4), ram_m[idx]);
      idx = $urandom % RAM_WORDS;
      read_expect("ram read", RAM_START + 32'(idx * 4), ram_m[idx]);
    end

    // Unmapped gap below the timer and space above the GPIO window
    for (int i = 0; i < 20; i++) begin
      if (i % 2 == 0) begin
        addr = RAM_END + (($urandom % 32'h0000_1F00) << 2);
      end else begin
        addr = GPIO_END + (($urandom % 32'h3FFF_DF00) << 2);
      end
      bus_write(addr, data_t'($urandom));
      read_expect("unmapped read", addr, '0);
    end
    read_expect("gpio dir after unmapped", GPIO_START + 32'(GPIO_DIR), '0);
    read_expect("gpio out after unmapped", GPIO_START + 32'(GPIO_OUT), '0);
    read_expect("timer cmp after unmapped", TIMER_START + 32'(TMR_CMP), '0);

    // GPIO outputs
    for (int i = 0; i < 12; i++) begin
      dir_m = gpio_t'($urandom);
      out_m = gpio_t'($urandom);
      bus_write(GPIO_START + 32'(GPIO_DIR), 32'(dir_m));
      bus_write(GPIO_START + 32'(GPIO_OUT), 32'(out_m));
      check("gpio_dir_o", 32'(gpio_dir_o), 32'(dir_m));
      check("gpio_val_o", 32'(gpio_val_o), 32'(out_m & dir_m));
      read_expect("gpio dir reg", GPIO_START + 32'(GPIO_DIR), 32'(dir_m));
      read_expect("gpio out reg", GPIO_START + 32'(GPIO_OUT), 32'(out_m & dir_m));
    end

    // GPIO inputs and sticky edge status
    for (int i = 0; i < 10; i++) begin
      pat = gpio_t'($urandom);
      if (i == 0) begin
        pat[0] = 1'b1;
      end
      settle_inputs(pat);
      read_expect("gpio in reg", GPIO_START + 32'(GPIO_IN), 32'(in_m));
      read_expect("gpio irq reg", GPIO_START + 32'(GPIO_IRQ), 32'(irq_m));
      check("gpio_irq_o", 32'(gpio_irq_o), 32'(|irq_m));
      if (gpio_irq_o) begin
        saw_irq = 1'b1;
      end
      if (i % 2 == 1) begin
        bus_write(GPIO_START + 32'(GPIO_IRQ), 32'(irq_m));
        irq_m = '0;
        read_expect("gpio irq cleared", GPIO_START + 32'(GPIO_IRQ), '0);
        check("gpio_irq_o cleared", 32'(gpio_irq_o), 32'd0);
      end
    end
    check("gpio_irq_o seen high", 32'(saw_irq), 32'd1);

    // Timer compare and interrupt
    cmp_m = 20 + ($urandom % 41);
    bus_write(TIMER_START + 32'(TMR_CMP), cmp_m);
    bus_write(TIMER_START + 32'(TMR_CTRL), 32'd1);
    read_expect("timer ctrl reg", TIMER_START + 32'(TMR_CTRL), 32'd1);
    read_expect("timer cmp reg", TIMER_START + 32'(TMR_CMP), cmp_m);
    wait_timer_irq();
    for (int i = 0; i < 10; i++) begin
      bus_read(TIMER_START + 32'(TMR_COUNT), value);
      check("timer count within compare", 32'(value <= cmp_m), 32'd1);
    end

    // Peripheral reset, with state set up beforehand
    settle_inputs(~in_m);
    bus_write(GPIO_START + 32'(GPIO_DIR), 32'(gpio_t'($urandom) | 8'h01));
    bus_write(GPIO_START + 32'(GPIO_OUT), 32'(gpio_t'($urandom) | 8'h01));
    issue_cmd(DBG_PERIPH_RST, '0, '0);
    dir_m = '0;
    out_m = '0;
    irq_m = '0;
    check("gpio_dir_o after reset", 32'(gpio_dir_o), 32'd0);
    check("gpio_val_o after reset", 32'(gpio_val_o), 32'd0);
    check("timer_irq_o after reset", 32'(timer_irq_o), 32'd0);
    check("gpio_irq_o after reset", 32'(gpio_irq_o), 32'd0);
    read_expect("gpio dir after reset", GPIO_START + 32'(GPIO_DIR), '0);
    read_expect("gpio out after reset", GPIO_START + 32'(GPIO_OUT), '0);
    read_expect("gpio irq after reset", GPIO_START + 32'(GPIO_IRQ), '0);
    read_expect("gpio in after reset", GPIO_START + 32'(GPIO_IN), 32'(in_m));
    read_expect("timer ctrl after reset", TIMER_START + 32'(TMR_CTRL), '0);
    read_expect("timer cmp after reset", TIMER_START + 32'(TMR_CMP), '0);
    read_expect("timer count after reset", TIMER_START + 32'(TMR_COUNT), '0);

    // RAM survives the peripheral reset
    for (int i = 0; i < RAM_WORDS; i++) begin
      read_expect("ram after reset", RAM_START + 32'(i * 4), ram_m[i]);
    end

    $display("Value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* soc_dbg.f */
common/soc_pkg.sv
debug/dbg_module.sv
source/wb_decoder.sv
source/wb_ram.sv
source/timer.sv
source/gpio_module.sv
source/core_wrapper.sv
testbench/tb_core_wrapper.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_core_wrapper -f soc_dbg.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
